/* scalar_unit.f */
+incdir+logic
logic/scalar_pkg.sv
logic/instr_mem.sv
logic/fetch_unit.sv
logic/hazard_check.sv
logic/reg_file.sv
logic/exec_unit.sv
logic/scalar_unit.sv
verification/scalar_unit_properties.sv
verification/scalar_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the scalar unit testbench with Verilator and runs it.
# The exit status is the simulator's, so a $fatal or a failed assertion fails the script.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
	--top-module scalar_unit_tb \
	-f scalar_unit.f \
	-o scalar_unit_sim

./obj_dir/scalar_unit_sim

/* verification/scalar_unit_tb.sv */
// Testbench for the scalar unit; loads a program, runs it under random back-pressure, checks outputs
`timescale 1ns/10ps
`include "scalar_defines.svh"

module scalar_unit_tb
	import scalar_pkg::*;
();

	localparam int WAIT_LIMIT = 200;
	localparam int RUN_LIMIT = 5000;
	localparam int REF_STEP_LIMIT = 1000;

	logic clock;
	logic reset;
	logic start;
	logic store_valid;
	instr_t store_instr;
	logic store_ready;
	logic out_valid;
	logic [`SCALAR_DATA_WIDTH-1:0] out_data;
	logic out_ready = 1'b0;
	logic term;

	instr_t program_words [`SCALAR_IMEM_DEPTH];
	logic [`SCALAR_PC_WIDTH-1:0] program_len = '0;
	logic [`SCALAR_DATA_WIDTH-1:0] expected_words [$];
	int recv_count = 0;
	int store_count = 0;
	logic term_seen = 1'b0;
	logic [31:0] lfsr_state = 32'h5a75ed39;

	scalar_unit scalar_unit_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.store_valid(store_valid),
		.store_instr(store_instr),
		.store_ready(store_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.out_ready(out_ready),
		.term(term)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	task automatic stop_with_error(input string line);
		$display("%s", line);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	function automatic instr_t encode(opcode_t op, int dst, int src1, int src2, int imm);
		instr_t w;
		w.opcode = op;
		w.dst = dst[`SCALAR_REG_IDX_WIDTH-1:0];
		w.src1 = src1[`SCALAR_REG_IDX_WIDTH-1:0];
		w.src2 = src2[`SCALAR_REG_IDX_WIDTH-1:0];
		w.imm = imm[`SCALAR_IMM_WIDTH-1:0];
		return w;
	endfunction

	task automatic emit(opcode_t op, int dst, int src1, int src2, int imm);
		program_words[program_len] = encode(op, dst, src1, src2, imm);
		program_len = program_len + 1'b1;
	endtask

	// Right-shifting Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return (s >> 1) ^ (s[0] ? 32'h80200003 : 32'h0);
	endfunction

	//////////////////////////////
	// Test program with its word addresses
	task automatic build_program();
		// 0-4 independent immediates
		emit(op_li, 1, 0, 0, 5);
		emit(op_li, 2, 0, 0, 7);
		emit(op_li, 3, 0, 0, 16'h1234);
		emit(op_out, 0, 1, 0, 0);
		emit(op_out, 0, 2, 0, 0);
		// 5-10 ALU on independent registers
		emit(op_add, 4, 1, 2, 0);
		emit(op_sub, 5, 2, 1, 0);
		emit(op_xor, 6, 1, 3, 0);
		emit(op_out, 0, 4, 0, 0);
		emit(op_out, 0, 5, 0, 0);
		emit(op_out, 0, 6, 0, 0);
		// 11-15 back-to-back dependent chain
		emit(op_add, 7, 4, 4, 0);
		emit(op_sub, 8, 7, 1, 0);
		emit(op_and, 9, 8, 3, 0);
		emit(op_or, 10, 9, 2, 0);
		emit(op_out, 0, 10, 0, 0);
		// 16-23 taken bz, untaken bz, jmp
		emit(op_li, 11, 0, 0, 0);
		emit(op_bz, 0, 11, 0, 19);
		emit(op_out, 0, 1, 0, 0);
		emit(op_bz, 0, 4, 0, 21);
		emit(op_out, 0, 2, 0, 0);
		emit(op_jmp, 0, 0, 0, 23);
		emit(op_out, 0, 3, 0, 0);
		emit(op_out, 0, 7, 0, 0);
		// 24-30 countdown loop, then halt
		emit(op_li, 12, 0, 0, 3);
		emit(op_li, 13, 0, 0, 1);
		emit(op_out, 0, 12, 0, 0);
		emit(op_sub, 12, 12, 13, 0);
		emit(op_bz, 0, 12, 0, 30);
		emit(op_jmp, 0, 0, 0, 26);
		emit(op_halt, 0, 0, 0, 0);
	endtask

	// ISA interpreter producing the expected result stream
	task automatic run_reference();
		logic [`SCALAR_DATA_WIDTH-1:0] regs [`SCALAR_NUM_REGS];
		instr_t w;
		logic [`SCALAR_PC_WIDTH-1:0] pc;
		int steps;
		logic done;
		for (int i = 0; i < `SCALAR_NUM_REGS; i++) begin
			regs[i] = '0;
		end
		pc = '0;
		steps = 0;
		done = 1'b0;
		while (!done) begin
			assert (steps < REF_STEP_LIMIT)
				else stop_with_error("reference model never reached halt");
			w = program_words[pc];
			pc = pc + 1'b1;
			case (w.opcode)
				op_add: regs[w.dst] = regs[w.src1] + regs[w.src2];
				op_sub: regs[w.dst] = regs[w.src1] - regs[w.src2];
				op_and: regs[w.dst] = regs[w.src1] & regs[w.src2];
				op_or: regs[w.dst] = regs[w.src1] | regs[w.src2];
				op_xor: regs[w.dst] = regs[w.src1] ^ regs[w.src2];
				op_li: regs[w.dst] = {{(`SCALAR_DATA_WIDTH-`SCALAR_IMM_WIDTH){1'b0}}, w.imm};
				op_jmp: pc = w.imm[`SCALAR_PC_WIDTH-1:0];
				op_bz: begin
					if (regs[w.src1] == '0) begin
						pc = w.imm[`SCALAR_PC_WIDTH-1:0];
					end
				end
				op_out: expected_words.push_back(regs[w.src1]);
				op_halt: done = 1'b1;
				default: ;
			endcase
			steps++;
		end
	endtask

	// One word per handshake; caller enters on a rising edge
	task automatic store_program();
		logic [`SCALAR_PC_WIDTH-1:0] addr;
		int waited;
		addr = '0;
		while (addr != program_len) begin
			store_valid <= 1'b1;
			store_instr <= program_words[addr];
			waited = 0;
			@(posedge clock);
			while (!store_ready) begin
				waited++;
				assert (waited < WAIT_LIMIT)
					else stop_with_error("store port never accepted a program word");
				@(posedge clock);
			end
			addr = addr + 1'b1;
		end
		store_valid <= 1'b0;
	endtask

	//////////////////////////////
	// Back-pressure on the result port
	always @(posedge clock) begin
		lfsr_state = lfsr_next(lfsr_state);
		out_ready <= lfsr_state[0];
	end

	// Result and store port monitor
	always @(posedge clock) begin
		if (!reset) begin
			assert (!(term_seen && out_valid))
				else stop_with_error("result word appeared after halt");
			if (out_valid && out_ready) begin
				assert (recv_count < expected_words.size())
					else stop_with_error("more result words than the reference model produced");
				assert (out_data == expected_words[recv_count])
					else stop_with_error($sformatf("mismatch at %0t: word %0d is %h, expected %h",
						$time, recv_count, out_data, expected_words[recv_count]));
				recv_count++;
			end
			if (term) begin
				term_seen <= 1'b1;
			end
			if (store_valid && store_ready) begin
				store_count++;
			end
		end
	end

	initial begin
		int waited;
		reset = 1'b1;
		start = 1'b0;
		store_valid = 1'b0;
		store_instr = '0;
		build_program();
		run_reference();

		repeat (10) @(posedge clock);
		reset <= 1'b0;
		@(posedge clock);
		assert (store_ready && !out_valid && !term)
			else stop_with_error("unit not idle after reset");

		store_program();
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;

		waited = 0;
		while (store_ready) begin
			waited++;
			assert (waited < WAIT_LIMIT)
				else stop_with_error("store_ready stayed high after start");
			@(posedge clock);
		end
		// Stray word offered while running must be refused
		store_valid <= 1'b1;
		store_instr <= encode(op_halt, 0, 0, 0, 0);

		waited = 0;
		while (!term) begin
			waited++;
			assert (waited < RUN_LIMIT)
				else stop_with_error("term never rose after the program was started");
			@(posedge clock);
		end
		repeat (20) @(posedge clock);

		if (recv_count == expected_words.size() && store_count == int'(program_len)) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			stop_with_error($sformatf("mismatch at %0t: %0d of %0d words received, %0d stores",
				$time, recv_count, expected_words.size(), store_count));
		end
	end

endmodule

/* verification/scalar_unit_properties.sv */
// Concurrent checks on the scalar unit ports; bound into every scalar_unit instance
`timescale 1ns/10ps
`include "scalar_defines.svh"

module scalar_unit_properties (
	input logic clock,
	input logic reset,
	input logic start,
	input logic store_ready,
	input logic out_valid,
	input logic out_ready,
	input logic [`SCALAR_DATA_WIDTH-1:0] out_data,
	input logic term
);

	//////////////////////////////
	// Result stream
	result_held: assert property (@(posedge clock) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("result word dropped or changed while out_ready was low");

	// Sticky end of run
	term_sticky: assert property (@(posedge clock) disable iff (reset)
		term |=> term)
		else $error("term fell before reset");

	//////////////////////////////
	// Store port closes at start and stays closed
	store_closes: assert property (@(posedge clock) disable iff (reset)
		start && store_ready |=> !store_ready)
		else $error("store port still open after start");

	store_stays_closed: assert property (@(posedge clock) disable iff (reset)
		!store_ready |=> !store_ready)
		else $error("store port reopened while running");

endmodule

bind scalar_unit scalar_unit_properties scalar_unit_properties_i (
	.clock(clock),
	.reset(reset),
	.start(start),
	.store_ready(store_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_data(out_data),
	.term(term)
);

/* logic/scalar_unit.sv */
// Scalar unit top; load a program on the store port, pulse start, then collect the result stream
`timescale 1ns/10ps
`include "scalar_defines.svh"

module scalar_unit
	import scalar_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic store_valid,
	input instr_t store_instr,
	output logic store_ready,
	output logic out_valid,
	output logic [`SCALAR_DATA_WIDTH-1:0] out_data,
	input logic out_ready,
	output logic term
);

	logic [`SCALAR_PC_WIDTH-1:0] mem_addr;
	instr_t mem_instr;
	fetch_t fetch;
	issue_t issue;
	exec_t exec;
	logic idle;
	logic accept;
	logic stall;
	logic redirect;
	logic [`SCALAR_PC_WIDTH-1:0] redirect_pc;
	logic branch_done;
	logic wb_valid;
	logic [`SCALAR_REG_IDX_WIDTH-1:0] wb_dst;
	logic [`SCALAR_DATA_WIDTH-1:0] wb_data;

	// Stores only while idle
	assign store_ready = idle;

	instr_mem instr_mem_i (
		.clock(clock),
		.reset(reset),
		.store_valid(store_valid),
		.store_instr(store_instr),
		.store_ready(idle),
		.start(start),
		.rd_addr(mem_addr),
		.rd_instr(mem_instr)
	);

	//////////////////////////////
	// Pipeline: fetch, issue, read, execute
	fetch_unit fetch_unit_i (
		.clock(clock),
		.reset(reset),
		.start(start),
		.stall(stall),
		.accept(accept),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.halted(term),
		.mem_instr(mem_instr),
		.mem_addr(mem_addr),
		.idle(idle),
		.fetch(fetch)
	);

	hazard_check hazard_check_i (
		.clock(clock),
		.reset(reset),
		.fetch(fetch),
		.stall(stall),
		.wb_valid(wb_valid),
		.wb_dst(wb_dst),
		.branch_done(branch_done),
		.accept(accept),
		.issue(issue)
	);

	reg_file reg_file_i (
		.clock(clock),
		.reset(reset),
		.issue(issue),
		.stall(stall),
		.wb_valid(wb_valid),
		.wb_dst(wb_dst),
		.wb_data(wb_data),
		.exec(exec)
	);

	exec_unit exec_unit_i (
		.clock(clock),
		.reset(reset),
		.exec(exec),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.out_data(out_data),
		.stall(stall),
		.wb_valid(wb_valid),
		.wb_dst(wb_dst),
		.wb_data(wb_data),
		.redirect(redirect),
		.redirect_pc(redirect_pc),
		.branch_done(branch_done),
		.term(term)
	);

endmodule

/* logic/exec_unit.sv */
// Execute stage; ALU and write-back, branch resolution, result stream and halt flag
`timescale 1ns/10ps
`include "scalar_defines.svh"

module exec_unit
	import scalar_pkg::*;
(
	input logic clock,
	input logic reset,
	input exec_t exec,
	input logic out_ready,
	output logic out_valid,
	output logic [`SCALAR_DATA_WIDTH-1:0] out_data,
	output logic stall,
	output logic wb_valid,
	output logic [`SCALAR_REG_IDX_WIDTH-1:0] wb_dst,
	output logic [`SCALAR_DATA_WIDTH-1:0] wb_data,
	output logic redirect,
	output logic [`SCALAR_PC_WIDTH-1:0] redirect_pc,
	output logic branch_done,
	output logic term
);

	opcode_t op;
	logic [`SCALAR_DATA_WIDTH-1:0] alu_result;
	logic is_branch;
	logic halt_now;
	logic term_q;

	assign op = exec.instr.opcode;

	//////////////////////////////
	// ALU
	always_comb begin
		case (op)
			op_add: alu_result = exec.a + exec.b;
			op_sub: alu_result = exec.a - exec.b;
			op_and: alu_result = exec.a & exec.b;
			op_or: alu_result = exec.a | exec.b;
			op_xor: alu_result = exec.a ^ exec.b;
			op_li: alu_result = {{(`SCALAR_DATA_WIDTH-`SCALAR_IMM_WIDTH){1'b0}}, exec.instr.imm};
			default: alu_result = '0;
		endcase
	end

	assign wb_valid = exec.valid & writes_reg(op);
	assign wb_dst = exec.instr.dst;
	assign wb_data = alu_result;

	// Jump always taken, bz taken on a zero source
	assign is_branch = op inside {op_jmp, op_bz};
	assign branch_done = exec.valid & is_branch;
	assign redirect = branch_done & ((op == op_jmp) | (exec.a == '0));
	assign redirect_pc = exec.instr.imm[`SCALAR_PC_WIDTH-1:0];

	//////////////////////////////
	// Result stream, held in place by freezing the pipe
	assign out_valid = exec.valid & (op == op_out);
	assign out_data = exec.a;
	assign stall = out_valid & ~out_ready;

	// Sticky end of run
	assign halt_now = exec.valid & (op == op_halt);

	always_ff @(posedge clock) begin
		if (reset) begin
			term_q <= 1'b0;
		end else if (halt_now) begin
			term_q <= 1'b1;
		end
	end

	assign term = term_q | halt_now;

endmodule

/* logic/reg_file.sv */
// Register read stage; general registers with two read ports feeding the execute register
`timescale 1ns/10ps
`include "scalar_defines.svh"

module reg_file
	import scalar_pkg::*;
(
	input logic clock,
	input logic reset,
	input issue_t issue,
	input logic stall,
	input logic wb_valid,
	input logic [`SCALAR_REG_IDX_WIDTH-1:0] wb_dst,
	input logic [`SCALAR_DATA_WIDTH-1:0] wb_data,
	output exec_t exec
);

	logic [`SCALAR_DATA_WIDTH-1:0] regs [`SCALAR_NUM_REGS];
	logic [`SCALAR_DATA_WIDTH-1:0] rd_a;
	logic [`SCALAR_DATA_WIDTH-1:0] rd_b;

	// Write port from execute
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `SCALAR_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_valid) begin
			regs[wb_dst] <= wb_data;
		end
	end

	// Read ports; sources are never pending here
	assign rd_a = regs[issue.instr.src1];
	assign rd_b = regs[issue.instr.src2];

	//////////////////////////////
	// Execute register
	always_ff @(posedge clock) begin
		if (reset) begin
			exec <= '0;
		end else if (!stall) begin
			exec.valid <= issue.valid;
			exec.instr <= issue.instr;
			exec.a <= rd_a;
			exec.b <= rd_b;
		end
	end

endmodule

/* logic/hazard_check.sv */
// Issue stage; scoreboards pending register writes and holds control flow until it resolves
`timescale 1ns/10ps
`include "scalar_defines.svh"

module hazard_check
	import scalar_pkg::*;
(
	input logic clock,
	input logic reset,
	input fetch_t fetch,
	input logic stall,
	input logic wb_valid,
	input logic [`SCALAR_REG_IDX_WIDTH-1:0] wb_dst,
	input logic branch_done,
	output logic accept,
	output issue_t issue
);

	logic [`SCALAR_NUM_REGS-1:0] pending;
	logic [`SCALAR_NUM_REGS-1:0] pending_set;
	logic [`SCALAR_NUM_REGS-1:0] pending_clr;
	logic ctrl_busy;
	opcode_t op;
	logic reads_a;
	logic reads_b;
	logic writes;
	logic is_ctrl;
	logic conflict;

	//////////////////////////////
	// Decode
	assign op = fetch.instr.opcode;
	assign writes = writes_reg(op);
	assign reads_b = op inside {op_add, op_sub, op_and, op_or, op_xor};
	assign reads_a = reads_b | (op == op_bz) | (op == op_out);
	// Halt counts as control and never resolves
	assign is_ctrl = op inside {op_jmp, op_bz, op_halt};

	// RAW on either source, WAW on the destination
	assign conflict = (reads_a & pending[fetch.instr.src1])
		| (reads_b & pending[fetch.instr.src2])
		| (writes & pending[fetch.instr.dst]);

	assign accept = fetch.valid & ~stall & ~ctrl_busy & ~conflict;

	//////////////////////////////
	// Scoreboard
	assign pending_set = ({{(`SCALAR_NUM_REGS-1){1'b0}}, 1'b1} << fetch.instr.dst)
		& {`SCALAR_NUM_REGS{accept & writes}};
	assign pending_clr = ({{(`SCALAR_NUM_REGS-1){1'b0}}, 1'b1} << wb_dst)
		& {`SCALAR_NUM_REGS{wb_valid}};

	always_ff @(posedge clock) begin
		if (reset) begin
			pending <= '0;
			ctrl_busy <= 1'b0;
		end else begin
			pending <= (pending & ~pending_clr) | pending_set;
			if (accept & is_ctrl) begin
				ctrl_busy <= 1'b1;
			end else if (branch_done) begin
				ctrl_busy <= 1'b0;
			end
		end
	end

	// Issue register, a bubble when nothing is accepted
	always_ff @(posedge clock) begin
		if (reset) begin
			issue <= '0;
		end else if (!stall) begin
			issue.valid <= accept;
			issue.instr <= fetch.instr;
		end
	end

endmodule

/* logic/fetch_unit.sv */
// Fetch stage; holds the run state and PC and presents one instruction at a time to issue
`timescale 1ns/10ps
`include "scalar_defines.svh"

module fetch_unit
	import scalar_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic start,
	input logic stall,
	input logic accept,
	input logic redirect,
	input logic [`SCALAR_PC_WIDTH-1:0] redirect_pc,
	input logic halted,
	input instr_t mem_instr,
	output logic [`SCALAR_PC_WIDTH-1:0] mem_addr,
	output logic idle,
	output fetch_t fetch
);

	logic running;
	logic [`SCALAR_PC_WIDTH-1:0] pc;
	logic load;

	assign idle = ~running;
	assign mem_addr = pc;

	// Refill when empty or when issue takes the current word
	assign load = running & ~halted & (~fetch.valid | accept);

	always_ff @(posedge clock) begin
		if (reset) begin
			running <= 1'b0;
			pc <= '0;
			fetch <= '0;
		end else if (idle & start) begin
			running <= 1'b1;
			pc <= '0;
		end else if (redirect) begin
			// Drop the fall-through word and restart at the target
			fetch.valid <= 1'b0;
			pc <= redirect_pc;
		end else if (!stall) begin
			if (load) begin
				fetch.valid <= 1'b1;
				fetch.instr <= mem_instr;
				fetch.pc <= pc;
				pc <= pc + 1'b1;
			end else if (accept) begin
				fetch.valid <= 1'b0;
			end
		end
	end

endmodule

/* logic/instr_mem.sv */
// Program memory; filled from the store port while idle and read combinationally by fetch
`timescale 1ns/10ps
`include "scalar_defines.svh"

module instr_mem (
	input logic clock,
	input logic reset,
	input logic store_valid,
	input scalar_pkg::instr_t store_instr,
	input logic store_ready,
	input logic start,
	input logic [`SCALAR_PC_WIDTH-1:0] rd_addr,
	output scalar_pkg::instr_t rd_instr
);

	scalar_pkg::instr_t mem [`SCALAR_IMEM_DEPTH];
	logic [`SCALAR_PC_WIDTH-1:0] store_addr;
	logic store_fire;

	assign store_fire = store_valid & store_ready;

	// Store address counter, rewound at start
	always_ff @(posedge clock) begin
		if (reset) begin
			store_addr <= '0;
		end else if (start & store_ready) begin
			store_addr <= '0;
		end else if (store_fire) begin
			store_addr <= store_addr + 1'b1;
		end
	end

	// Program array
	always_ff @(posedge clock) begin
		if (store_fire) begin
			mem[store_addr] <= store_instr;
		end
	end

	// Asynchronous read for the fetch stage
	assign rd_instr = mem[rd_addr];

endmodule

/* logic/scalar_pkg.sv */
// Opcode, instruction and pipeline payload types shared by the scalar unit stages
`include "scalar_defines.svh"

package scalar_pkg;

	//////////////////////////////
	// Instruction set
	typedef enum logic [3:0] {
		op_nop  = 4'd0,
		op_add  = 4'd1,
		op_sub  = 4'd2,
		op_and  = 4'd3,
		op_or   = 4'd4,
		op_xor  = 4'd5,
		op_li   = 4'd6,
		op_jmp  = 4'd7,
		op_bz   = 4'd8,
		op_out  = 4'd9,
		op_halt = 4'd10
	} opcode_t;

	// 4 + 4 + 4 + 4 + 16 bits
	typedef struct packed {
		opcode_t opcode;
		logic [`SCALAR_REG_IDX_WIDTH-1:0] dst;
		logic [`SCALAR_REG_IDX_WIDTH-1:0] src1;
		logic [`SCALAR_REG_IDX_WIDTH-1:0] src2;
		logic [`SCALAR_IMM_WIDTH-1:0] imm;
	} instr_t;

	//////////////////////////////
	// Stage payloads
	typedef struct packed {
		logic valid;
		instr_t instr;
		logic [`SCALAR_PC_WIDTH-1:0] pc;
	} fetch_t;

	typedef struct packed {
		logic valid;
		instr_t instr;
	} issue_t;

	typedef struct packed {
		logic valid;
		instr_t instr;
		logic [`SCALAR_DATA_WIDTH-1:0] a;
		logic [`SCALAR_DATA_WIDTH-1:0] b;
	} exec_t;

	// Opcodes that write their destination register
	function automatic logic writes_reg(opcode_t op);
		return op inside {op_add, op_sub, op_and, op_or, op_xor, op_li};
	endfunction

endpackage

/* logic/scalar_defines.svh */
// Width, register count and memory depth macros for the scalar unit, included by every RTL file
`ifndef SCALAR_DEFINES_SVH
`define SCALAR_DEFINES_SVH

// Data path
`define SCALAR_DATA_WIDTH 32

// Register file
`define SCALAR_NUM_REGS 16
`define SCALAR_REG_IDX_WIDTH 4

// Instruction memory, PC wraps at the depth
`define SCALAR_IMEM_DEPTH 64
`define SCALAR_PC_WIDTH 6

// Immediate field in the instruction word
`define SCALAR_IMM_WIDTH 16

`endif
